// ==== logic/cache_pkg.sv ====
// ================================================
// cache_pkg
// widths, vector types, opcodes and result codes
// shared by the set-associative lookup pipe
// ================================================
package cache_pkg;

  // ================================================
  // geometry
  // ================================================
  localparam int NUM_WAYS      = 4;   // ways per set
  localparam int WAY_WIDTH     = 2;   // encoded way
  localparam int SET_WIDTH     = 4;   // 16 sets
  localparam int TAG_WIDTH     = 8;
  localparam int OFFSET_WIDTH  = 4;   // byte offset inside a line
  localparam int WORD_WIDTH    = 32;
  localparam int WORDS_IN_LINE = 4;

  // derived sizes
  localparam int ADDR_WIDTH      = TAG_WIDTH + SET_WIDTH + OFFSET_WIDTH;
  localparam int LINE_WIDTH      = WORD_WIDTH * WORDS_IN_LINE;
  localparam int WORD_SEL_WIDTH  = $clog2(WORDS_IN_LINE);  // upper offset bits
  localparam int LINE_ADDR_WIDTH = SET_WIDTH + WAY_WIDTH;
  localparam int NUM_SETS        = 1 << SET_WIDTH;
  localparam int NUM_LINES       = 1 << LINE_ADDR_WIDTH;    // data array depth

  // ================================================
  // vector types
  // ================================================
  typedef logic [ADDR_WIDTH-1:0]      addr_t;      // {tag, set, offset}
  typedef logic [TAG_WIDTH-1:0]       tag_t;
  typedef logic [SET_WIDTH-1:0]       set_t;
  typedef logic [OFFSET_WIDTH-1:0]    offset_t;    // msbs pick the word
  typedef logic [WORD_WIDTH-1:0]      word_t;
  typedef logic [LINE_WIDTH-1:0]      line_t;      // word 0 in the low bits
  typedef logic [NUM_WAYS-1:0]        way_vec_t;   // valid, mru, modified, hit, victim
  typedef logic [WAY_WIDTH-1:0]       way_t;
  typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t; // {set, way}
  typedef logic [3:0]                 lu_id_t;     // requester transaction id

  // ================================================
  // opcodes and result codes
  // ================================================
  typedef enum logic [1:0] {
    RD_LU   = 2'd0,
    WR_LU   = 2'd1,
    FILL_LU = 2'd2
  } lu_op_t;

  typedef enum logic [1:0] {
    NO_RSP = 2'd0,  // idle slot
    HIT    = 2'd1,
    MISS   = 2'd2,
    FILL   = 2'd3
  } lu_result_t;

  // far memory request kind
  typedef enum logic {
    FILL_REQ_OP    = 1'b0,
    DIRTY_EVICT_OP = 1'b1
  } fm_op_t;

endpackage

// ==== logic/lookup_if.sv ====
// ================================================
// lookup_if
// one lookup in q3, from tag_stage to rsp_stage
// ================================================
interface lookup_if;
  import cache_pkg::*;

  logic       valid;         // lookup present in q3
  lu_op_t     op;
  lu_id_t     id;
  tag_t       tag;
  set_t       set;
  offset_t    offset;
  word_t      word;          // write data
  line_t      cl_data;       // fill line
  logic       hit;
  line_addr_t line_addr;     // hit way, or victim way on a fill
  logic       dirty_evict;   // victim was valid and modified
  tag_t       victim_tag;    // tag before the fill overwrote it
  logic       fill_modified;

  // tag_stage side
  modport producer (
    output valid, op, id, tag, set, offset, word, cl_data,
    output hit, line_addr, dirty_evict, victim_tag, fill_modified
  );

  // rsp_stage side
  modport consumer (
    input valid, op, id, tag, set, offset, word, cl_data,
    input hit, line_addr, dirty_evict, victim_tag, fill_modified
  );

endinterface

// ==== logic/tag_stage.sv ====
// ================================================
// tag_stage
// tag array with q3 set forwarding, tag compare,
// victim choice and set update, q1 and q2 of the pipe
// ================================================
module tag_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lu_valid,
  input  cache_pkg::lu_op_t     lu_op,
  input  cache_pkg::addr_t      lu_address,
  input  cache_pkg::word_t      lu_data,
  input  cache_pkg::line_t      lu_cl_data,
  input  logic                  lu_fill_modified,
  input  cache_pkg::lu_id_t     lu_id,
  output cache_pkg::line_addr_t rd_line_addr,
  lookup_if.producer            lu
);
  import cache_pkg::*;

  // one hot to binary, single way expected
  function automatic way_t enc_way(way_vec_t vec);
    way_t enc;
    enc = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (vec[w]) enc = way_t'(w);
    end
    return enc;
  endfunction

  set_t                q1_set;
  tag_t                q1_tag;
  offset_t             q1_offset;
  tag_t [NUM_WAYS-1:0] tag_mem [NUM_SETS];    // no reset, guarded by valid
  way_vec_t            valid_mem [NUM_SETS];
  way_vec_t            mru_mem [NUM_SETS];
  way_vec_t            mod_mem [NUM_SETS];
  logic                valid_q2;
  lu_op_t              op_q2;
  lu_id_t              id_q2;
  tag_t                tag_q2;
  set_t                set_q2;
  offset_t             offset_q2;
  word_t               word_q2;
  line_t               cl_data_q2;
  logic                fill_mod_q2;
  tag_t [NUM_WAYS-1:0] rd_tags_q2;            // raw set read
  way_vec_t            rd_valid_q2, rd_mru_q2, rd_mod_q2;
  tag_t [NUM_WAYS-1:0] fwd_tags;              // set written by the q3 lookup
  way_vec_t            fwd_valid, fwd_mru, fwd_mod;
  logic                hazard_q2;
  tag_t [NUM_WAYS-1:0] set_tags_q2;           // effective set
  way_vec_t            set_valid_q2, set_mru_q2, set_mod_q2;
  way_vec_t            hit_vec_q2, free_vec_q2, lru_vec_q2;
  way_vec_t            first_free_q2, first_lru_q2, victim_vec_q2, used_vec_q2;
  way_t                hit_way_q2, victim_way_q2;
  logic                hit_q2, dirty_evict_q2;
  tag_t [NUM_WAYS-1:0] new_tags_q2;           // updated set
  way_vec_t            new_valid_q2, new_mru_q2, new_mod_q2;

  // ================================================
  // q1 address split and set read
  // ================================================
  assign q1_tag    = lu_address[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign q1_set    = lu_address[OFFSET_WIDTH +: SET_WIDTH];
  assign q1_offset = lu_address[OFFSET_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) valid_q2 <= 1'b0;
    else        valid_q2 <= lu_valid;
  end

  always_ff @(posedge clk) begin
    op_q2       <= lu_op;
    id_q2       <= lu_id;
    tag_q2      <= q1_tag;
    set_q2      <= q1_set;
    offset_q2   <= q1_offset;
    word_q2     <= lu_data;
    cl_data_q2  <= lu_cl_data;
    fill_mod_q2 <= lu_fill_modified && (lu_op == FILL_LU);
    rd_tags_q2  <= tag_mem[q1_set];   // old copy if q2 writes the same set now
    rd_valid_q2 <= valid_mem[q1_set];
    rd_mru_q2   <= mru_mem[q1_set];
    rd_mod_q2   <= mod_mem[q1_set];
  end

  // ================================================
  // q2 forward, compare, victim
  // ================================================
  assign hazard_q2    = valid_q2 && lu.valid && (lu.set == set_q2);
  assign set_tags_q2  = hazard_q2 ? fwd_tags  : rd_tags_q2;
  assign set_valid_q2 = hazard_q2 ? fwd_valid : rd_valid_q2;
  assign set_mru_q2   = hazard_q2 ? fwd_mru   : rd_mru_q2;
  assign set_mod_q2   = hazard_q2 ? fwd_mod   : rd_mod_q2;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec_q2[w] = valid_q2 && set_valid_q2[w] && (set_tags_q2[w] == tag_q2);
    end
  end
  assign hit_q2     = |hit_vec_q2;
  assign hit_way_q2 = enc_way(hit_vec_q2);

  // free ways first, then first non mru, then way 0
  assign free_vec_q2   = ~set_valid_q2;
  assign lru_vec_q2    = ~set_mru_q2;
  assign first_free_q2 = free_vec_q2 & (~free_vec_q2 + way_vec_t'(1));  // lowest set bit
  assign first_lru_q2  = lru_vec_q2 & (~lru_vec_q2 + way_vec_t'(1));
  assign victim_vec_q2 = (op_q2 != FILL_LU) ? '0            :
                         (|free_vec_q2)     ? first_free_q2 :
                         (|lru_vec_q2)      ? first_lru_q2  :
                                              way_vec_t'(1);
  assign victim_way_q2  = enc_way(victim_vec_q2);
  assign dirty_evict_q2 = |(victim_vec_q2 & set_valid_q2 & set_mod_q2);
  assign used_vec_q2    = (op_q2 == FILL_LU) ? victim_vec_q2 : hit_vec_q2;

  // data array read for q3
  assign rd_line_addr = {set_q2, (op_q2 == FILL_LU) ? victim_way_q2 : hit_way_q2};

  // ================================================
  // q2 set update
  // ================================================
  always_comb begin
    new_tags_q2  = set_tags_q2;   // keep by default
    new_valid_q2 = set_valid_q2;
    new_mru_q2   = set_mru_q2;
    new_mod_q2   = set_mod_q2;
    case (op_q2)
      RD_LU: if (hit_q2) new_mru_q2 = set_mru_q2 | hit_vec_q2;
      WR_LU: begin
        if (hit_q2) begin
          new_mru_q2 = set_mru_q2 | hit_vec_q2;
          new_mod_q2 = set_mod_q2 | hit_vec_q2;   // line now dirty
        end
      end
      FILL_LU: begin
        new_tags_q2[victim_way_q2] = tag_q2;
        new_valid_q2 = set_valid_q2 | victim_vec_q2;
        new_mru_q2   = set_mru_q2 | victim_vec_q2;
        new_mod_q2   = fill_mod_q2 ? (set_mod_q2 | victim_vec_q2) :
                                     (set_mod_q2 & ~victim_vec_q2);
      end
      default: ;
    endcase
    if (&new_mru_q2) new_mru_q2 = used_vec_q2;   // mru flip
  end

  always_ff @(posedge clk) begin
    if (valid_q2) tag_mem[set_q2] <= new_tags_q2;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        mru_mem[s]   <= '0;
        mod_mem[s]   <= '0;
      end
    end else if (valid_q2) begin
      valid_mem[set_q2] <= new_valid_q2;
      mru_mem[set_q2]   <= new_mru_q2;
      mod_mem[set_q2]   <= new_mod_q2;
    end
  end

  // ================================================
  // q2 to q3 register
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) lu.valid <= 1'b0;
    else        lu.valid <= valid_q2;
  end

  always_ff @(posedge clk) begin
    lu.op            <= op_q2;
    lu.id            <= id_q2;
    lu.tag           <= tag_q2;
    lu.set           <= set_q2;
    lu.offset        <= offset_q2;
    lu.word          <= word_q2;
    lu.cl_data       <= cl_data_q2;
    lu.hit           <= hit_q2;
    lu.line_addr     <= rd_line_addr;
    lu.dirty_evict   <= dirty_evict_q2;
    lu.victim_tag    <= set_tags_q2[victim_way_q2];  // before the fill
    lu.fill_modified <= fill_mod_q2;
    fwd_tags         <= new_tags_q2;   // for the next q2
    fwd_valid        <= new_valid_q2;
    fwd_mru          <= new_mru_q2;
    fwd_mod          <= new_mod_q2;
  end

endmodule

// ==== logic/data_array.sv ====
// ================================================
// data_array
// 64 line store, registered read, one cycle pending
// write with bypass to reads of the same line
// ================================================
module data_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::line_addr_t rd_line_addr,
  output cache_pkg::line_t      rd_line,
  input  logic                  wr_valid,
  input  cache_pkg::line_addr_t wr_line_addr,
  input  cache_pkg::line_t      wr_line
);
  import cache_pkg::*;

  line_t      mem [NUM_LINES];   // {set, way} indexed
  logic       pend_valid;        // write held from q3
  line_addr_t pend_addr;
  line_t      pend_data;
  line_addr_t rd_addr_q3;
  line_t      rd_raw_q3;
  logic       pend_hit_q2;
  logic       pend_hit_q3;

  // ================================================
  // pending write and commit
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pend_valid <= 1'b0;
    else        pend_valid <= wr_valid;
  end

  always_ff @(posedge clk) begin
    pend_addr <= wr_line_addr;
    pend_data <= wr_line;
    if (pend_valid) mem[pend_addr] <= pend_data;  // commit one edge later
  end

  // ================================================
  // read path
  // ================================================
  // pending write not yet in mem when the read is captured
  assign pend_hit_q2 = pend_valid && (pend_addr == rd_line_addr);

  always_ff @(posedge clk) begin
    rd_addr_q3 <= rd_line_addr;
    rd_raw_q3  <= pend_hit_q2 ? pend_data : mem[rd_line_addr];
  end

  // write from the lookup just ahead is newer still
  assign pend_hit_q3 = pend_valid && (pend_addr == rd_addr_q3);
  assign rd_line     = pend_hit_q3 ? pend_data : rd_raw_q3;

endmodule

// ==== logic/rsp_stage.sv ====
// ================================================
// rsp_stage
// q3 write merge, lookup response and far memory request
// ================================================
module rsp_stage (
  lookup_if.consumer            lu,
  input  cache_pkg::line_t      rd_line,
  output logic                  wr_valid,
  output cache_pkg::line_addr_t wr_line_addr,
  output cache_pkg::line_t      wr_line,
  output logic                  rsp_valid,
  output cache_pkg::lu_op_t     rsp_op,
  output cache_pkg::lu_result_t rsp_result,
  output cache_pkg::lu_id_t     rsp_id,
  output cache_pkg::addr_t      rsp_address,
  output cache_pkg::line_t      rsp_cl_data,
  output logic                  fm_req_valid,
  output cache_pkg::fm_op_t     fm_req_op,
  output cache_pkg::addr_t      fm_req_address,
  output cache_pkg::line_t      fm_req_data,
  output cache_pkg::lu_id_t     fm_req_id
);
  import cache_pkg::*;

  logic                      is_fill;
  logic                      is_read_hit;
  logic                      is_write_hit;
  logic                      is_miss;      // read or write miss
  logic                      is_dirty_fill;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  line_t                     merged_line;
  addr_t                     lu_address;

  assign is_fill       = lu.op == FILL_LU;
  assign is_read_hit   = (lu.op == RD_LU) && lu.hit;
  assign is_write_hit  = (lu.op == WR_LU) && lu.hit;
  assign is_miss       = lu.valid && !is_fill && !lu.hit;
  assign is_dirty_fill = lu.valid && is_fill && lu.dirty_evict;
  assign lu_address    = {lu.tag, lu.set, lu.offset};

  // ================================================
  // response
  // ================================================
  assign rsp_valid   = lu.valid;
  assign rsp_op      = lu.op;
  assign rsp_id      = lu.id;
  assign rsp_address = lu_address;

  always_comb begin
    if (!lu.valid)   rsp_result = NO_RSP;
    else if (is_fill) rsp_result = FILL;
    else if (lu.hit)  rsp_result = HIT;
    else              rsp_result = MISS;
  end

  assign rsp_cl_data = is_fill     ? lu.cl_data :
                       is_read_hit ? rd_line    :
                                     '0;

  // ================================================
  // write merge back into the data array
  // ================================================
  assign word_sel = lu.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];

  always_comb begin
    merged_line = rd_line;                                  // current line
    merged_line[word_sel*WORD_WIDTH +: WORD_WIDTH] = lu.word; // replace one word
  end

  assign wr_valid     = lu.valid && (is_fill || is_write_hit);
  assign wr_line_addr = lu.line_addr;
  assign wr_line      = is_fill ? lu.cl_data : merged_line;

  // ================================================
  // far memory request
  // ================================================
  always_comb begin
    fm_req_valid   = 1'b0;
    fm_req_op      = FILL_REQ_OP;
    fm_req_address = '0;
    fm_req_data    = '0;
    fm_req_id      = lu.id;
    if (is_miss) begin
      // line fetch for a read or write miss
      fm_req_valid   = 1'b1;
      fm_req_op      = FILL_REQ_OP;
      fm_req_address = lu_address;
    end else if (is_dirty_fill) begin
      // old line leaves with its own tag
      fm_req_valid   = 1'b1;
      fm_req_op      = DIRTY_EVICT_OP;
      fm_req_address = {lu.victim_tag, lu.set, offset_t'(0)};
      fm_req_data    = rd_line;
    end
  end

endmodule

// ==== logic/d_cache.sv ====
// ================================================
// d_cache
// four way data cache lookup pipe, three stages
// ================================================
module d_cache (
  input  logic                  clk,
  input  logic                  rst_n,
  // lookup in
  input  logic                  lu_valid,
  input  cache_pkg::lu_op_t     lu_op,
  input  cache_pkg::addr_t      lu_address,
  input  cache_pkg::word_t      lu_data,
  input  cache_pkg::line_t      lu_cl_data,
  input  logic                  lu_fill_modified,
  input  cache_pkg::lu_id_t     lu_id,
  // response out
  output logic                  rsp_valid,
  output cache_pkg::lu_op_t     rsp_op,
  output cache_pkg::lu_result_t rsp_result,
  output cache_pkg::lu_id_t     rsp_id,
  output cache_pkg::addr_t      rsp_address,
  output cache_pkg::line_t      rsp_cl_data,
  // far memory request out
  output logic                  fm_req_valid,
  output cache_pkg::fm_op_t     fm_req_op,
  output cache_pkg::addr_t      fm_req_address,
  output cache_pkg::line_t      fm_req_data,
  output cache_pkg::lu_id_t     fm_req_id
);
  import cache_pkg::*;

  line_addr_t rd_line_addr;   // q2 read
  line_t      rd_line;        // q3 data
  logic       wr_valid;       // q3 write
  line_addr_t wr_line_addr;
  line_t      wr_line;

  lookup_if lu_bus ();

  tag_stage tag_stage_i (
    .clk, .rst_n, .lu_valid, .lu_op, .lu_address, .lu_data, .lu_cl_data,
    .lu_fill_modified, .lu_id, .rd_line_addr, .lu(lu_bus.producer)
  );

  data_array data_array_i (
    .clk, .rst_n, .rd_line_addr, .rd_line, .wr_valid, .wr_line_addr, .wr_line
  );

  rsp_stage rsp_stage_i (
    .lu(lu_bus.consumer), .rd_line, .wr_valid, .wr_line_addr, .wr_line,
    .rsp_valid, .rsp_op, .rsp_result, .rsp_id, .rsp_address, .rsp_cl_data,
    .fm_req_valid, .fm_req_op, .fm_req_address, .fm_req_data, .fm_req_id
  );

endmodule

// ==== tb/d_cache_asserts.sv ====
// ==================================================
// d_cache_asserts
// q3 output rules of rsp_stage, bound to every copy
// ==================================================
module d_cache_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  lu_valid,
  input cache_pkg::lu_op_t     lu_op,
  input logic                  lu_hit,
  input logic                  rsp_valid,
  input cache_pkg::lu_result_t rsp_result,
  input logic                  fm_req_valid,
  input logic                  wr_valid
);
  timeunit 1ns;
  timeprecision 1ps;
  import cache_pkg::*;

  int error_count = 0;   // assertion failures so far

  // nothing leaves q3 without a lookup
  a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !lu_valid |-> (!rsp_valid && !fm_req_valid && !wr_valid))
    else begin
      error_count++;
      $error("response, request or write without a q3 lookup");
    end

  a_fill_result_op: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_result == FILL) |-> (lu_op == FILL_LU))   // FILL only answers a fill
    else begin
      error_count++;
      $error("FILL result for a lookup that is not a fill");
    end

  // line write only for a write hit or a fill
  a_write_source: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid |-> ((lu_op == FILL_LU) || ((lu_op == WR_LU) && lu_hit)))
    else begin
      error_count++;
      $error("data array write without a write hit or a fill");
    end

endmodule

bind rsp_stage d_cache_asserts asserts_i (
  .clk(d_cache.clk), .rst_n(d_cache.rst_n), .lu_valid(lu.valid), .lu_op(lu.op),
  .lu_hit(lu.hit), .rsp_valid, .rsp_result, .fm_req_valid, .wr_valid
);

// ==== tb/d_cache_tb.sv ====
// ==================================================
// d_cache_tb
// random lookups against a sequential cache model,
// each result checked two edges after issue
// ==================================================
module d_cache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cache_pkg::*;

  localparam int NUM_RANDOM  = 400;
  localparam int NUM_LOOKUPS = NUM_RANDOM + 64;       // directed part stays under 64 cycles
  localparam int TIMEOUT_NS  = (NUM_LOOKUPS + 200) * 8;

  typedef struct packed {
    logic        valid;
    lu_op_t      op;
    lu_result_t  result;
    lu_id_t      id;
    addr_t       addr;
    line_t       cl_data;
    logic        fm_valid;
    fm_op_t      fm_op;
    addr_t       fm_addr;
    line_t       fm_data;
    logic [31:0] due;       // checker cycle of the response
  } expect_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       lu_valid, lu_fill_modified, rsp_valid, fm_req_valid;
  lu_op_t     lu_op, rsp_op;
  addr_t      lu_address, rsp_address, fm_req_address;
  word_t      lu_data;
  line_t      lu_cl_data, rsp_cl_data, fm_req_data;
  lu_id_t     lu_id, rsp_id, fm_req_id, next_id;
  lu_result_t rsp_result;
  fm_op_t     fm_req_op;

  // ==================================================
  // reference model state
  // ==================================================
  tag_t        m_tag [NUM_SETS][NUM_WAYS];
  line_t       m_line [NUM_SETS][NUM_WAYS];
  way_vec_t    m_valid [NUM_SETS];
  way_vec_t    m_mru [NUM_SETS];
  way_vec_t    m_mod [NUM_SETS];
  expect_t     exp_q [$];
  string       name_q [$];     // test name per queued result
  string       test_name = "reset";
  integer      seed = 32'h4ada_2572;
  logic [31:0] cycle_cnt = '0;

  d_cache d_cache_i (.*);

  always #4 clk = ~clk;   // 8 ns period

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_op(string what, lu_op_t exp, lu_op_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_result(string what, lu_result_t exp, lu_result_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_line(string what, line_t exp, line_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(string what, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_id(string what, lu_id_t exp, lu_id_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_fm_op(string what, fm_op_t exp, fm_op_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", what, exp, act);
      abort_run();
    end
  endtask

  function automatic addr_t make_addr(tag_t t, set_t s, offset_t o);
    return {t, s, o};
  endfunction

  function automatic line_t rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic holds(addr_t a);
    logic found;
    found = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[a[7:4]][w] && (m_tag[a[7:4]][w] == a[15:8])) found = 1'b1;
    end
    return found;
  endfunction

  // ==================================================
  // stimulus, one call per falling edge
  // ==================================================
  task automatic idle(int cycles);
    expect_t e;
    repeat (cycles) begin
      @(negedge clk);
      lu_valid = 1'b0;
      e = '0;              // no response, no request
      e.due = cycle_cnt + 2;
      exp_q.push_back(e);
      name_q.push_back(test_name);
    end
  endtask

  task automatic issue(lu_op_t op, addr_t addr, word_t word, line_t cl, logic fmod);
    expect_t  e;
    tag_t     tag;
    set_t     set;
    way_vec_t hit_vec, used;
    int       way, free_way, lru_way, sel;
    @(negedge clk);
    tag     = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    set     = addr[OFFSET_WIDTH +: SET_WIDTH];
    sel     = addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
    hit_vec = '0;
    way     = 0;
    free_way = -1;
    lru_way  = -1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin   // downward so the lowest way wins
      if (m_valid[set][w] && (m_tag[set][w] == tag)) begin
        hit_vec[w] = 1'b1;
        way = w;
      end
      if (!m_valid[set][w]) free_way = w;
      if (!m_mru[set][w]) lru_way = w;
    end
    e = '0;
    e.valid = 1'b1;
    e.op    = op;
    e.id    = next_id;
    e.addr  = addr;
    if (op == FILL_LU) begin
      way = (free_way >= 0) ? free_way : (lru_way >= 0) ? lru_way : 0;
      if (m_valid[set][way] && m_mod[set][way]) begin   // old line goes out
        e.fm_valid = 1'b1;
        e.fm_op    = DIRTY_EVICT_OP;
        e.fm_addr  = make_addr(m_tag[set][way], set, '0);
        e.fm_data  = m_line[set][way];
      end
      e.result = FILL;
      e.cl_data = cl;
      m_tag[set][way]   = tag;
      m_line[set][way]  = cl;
      m_valid[set][way] = 1'b1;
      m_mod[set][way]   = fmod;
      used = way_vec_t'(1) << way;
    end else if (|hit_vec) begin
      e.result = HIT;
      if (op == RD_LU) e.cl_data = m_line[set][way];
      else begin
        m_line[set][way][sel*WORD_WIDTH +: WORD_WIDTH] = word;
        m_mod[set][way] = 1'b1;
      end
      used = hit_vec;
    end else begin
      e.result   = MISS;      // line fetch, zero data
      e.fm_valid = 1'b1;
      e.fm_op    = FILL_REQ_OP;
      e.fm_addr  = addr;
      used = '0;
    end
    m_mru[set] = m_mru[set] | used;
    if (&m_mru[set]) m_mru[set] = used;   // only the way just used stays mru
    lu_valid         = 1'b1;
    lu_op            = op;
    lu_address       = addr;
    lu_data          = word;
    lu_cl_data       = cl;
    lu_fill_modified = fmod;
    lu_id            = next_id;
    next_id++;
    e.due = cycle_cnt + 2;
    exp_q.push_back(e);
    name_q.push_back(test_name);
  endtask

  // ==================================================
  // checker, outputs sampled before the edge updates them
  // ==================================================
  task automatic compare_front();
    expect_t e;
    string   tn;
    e  = exp_q.pop_front();
    tn = name_q.pop_front();
    check_flag({tn, " rsp_valid"}, e.valid, rsp_valid);
    check_flag({tn, " fm_req_valid"}, e.fm_valid, fm_req_valid);
    if (e.valid) begin
      check_op({tn, " rsp_op"}, e.op, rsp_op);
      check_result({tn, " rsp_result"}, e.result, rsp_result);
      check_id({tn, " rsp_id"}, e.id, rsp_id);
      check_addr({tn, " rsp_address"}, e.addr, rsp_address);
      check_line({tn, " rsp_cl_data"}, e.cl_data, rsp_cl_data);
    end
    if (e.fm_valid) begin
      check_fm_op({tn, " fm_req_op"}, e.fm_op, fm_req_op);
      check_addr({tn, " fm_req_address"}, e.fm_addr, fm_req_address);
      check_line({tn, " fm_req_data"}, e.fm_data, fm_req_data);
      check_id({tn, " fm_req_id"}, e.id, fm_req_id);
    end
  endtask

  always @(posedge clk) begin
    if (d_cache_i.rsp_stage_i.asserts_i.error_count != 0) begin
      $display("a concurrent assertion on rsp_stage failed");
      abort_run();
    end
    if ((exp_q.size() > 0) && (exp_q[0].due == cycle_cnt)) compare_front();
    cycle_cnt = cycle_cnt + 1;
  end

  initial begin
    #TIMEOUT_NS;
    $display("watchdog expired before all lookups were answered");
    abort_run();
  end

  initial begin
    logic [31:0] r;
    addr_t       a;
    lu_op_t      op;
    lu_valid         = 1'b0;
    lu_op            = RD_LU;
    lu_address       = '0;
    lu_data          = '0;
    lu_cl_data       = '0;
    lu_fill_modified = 1'b0;
    lu_id            = '0;
    next_id          = '0;
    rst_n            = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin   // empty cache after reset
      m_valid[s] = '0;
      m_mru[s]   = '0;
      m_mod[s]   = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "idle";
    idle(6);
    test_name = "miss";
    issue(RD_LU, make_addr(8'h11, 4'h2, 4'h4), '0, '0, 1'b0);
    issue(WR_LU, make_addr(8'h12, 4'h2, 4'h8), $random(seed), '0, 1'b0);
    issue(RD_LU, make_addr(8'h12, 4'h2, 4'h0), '0, '0, 1'b0);   // write miss left no line
    test_name = "fill_hit";
    issue(FILL_LU, make_addr(8'h11, 4'h2, 4'h0), '0, rand_line(), 1'b0);
    issue(RD_LU, make_addr(8'h11, 4'h2, 4'h4), '0, '0, 1'b0);   // same set, back to back
    idle(1);
    issue(RD_LU, make_addr(8'h11, 4'h2, 4'hc), '0, '0, 1'b0);
    test_name = "write_merge";
    issue(WR_LU, make_addr(8'h11, 4'h2, 4'h8), $random(seed), '0, 1'b0);
    issue(RD_LU, make_addr(8'h11, 4'h2, 4'h0), '0, '0, 1'b0);
    test_name = "victim";
    for (int t = 0; t < 6; t++) issue(FILL_LU, make_addr(tag_t'(8'h30 + t), 4'h5, 4'h0),
                                      '0, rand_line(), 1'b0);
    for (int t = 0; t < 6; t++) issue(RD_LU, make_addr(tag_t'(8'h30 + t), 4'h5, 4'h4),
                                      '0, '0, 1'b0);
    test_name = "dirty_evict";
    for (int t = 0; t < 6; t++) issue(WR_LU, make_addr(tag_t'(8'h30 + t), 4'h5, 4'h4),
                                      $random(seed), '0, 1'b0);
    for (int t = 0; t < 6; t++) issue(FILL_LU, make_addr(tag_t'(8'h40 + t), 4'h5, 4'h0),
                                      '0, rand_line(), t[0]);

    test_name = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = $random(seed);
      a = make_addr({5'b01010, r[2:0]}, {2'b01, r[4:3]}, r[8:5]);   // 8 tags over 4 sets
      if (r[11:9] == 3'd7) idle(1);
      else begin
        op = (r[11:9] < 3'd3) ? RD_LU : (r[11:9] < 3'd5) ? WR_LU : FILL_LU;
        if ((op == FILL_LU) && holds(a)) op = RD_LU;   // fill only absent lines
        issue(op, a, $random(seed), rand_line(), r[12]);
      end
    end

    test_name = "drain";
    idle(4);
    wait (exp_q.size() == 0);
    @(negedge clk);
    if (d_cache_i.rsp_stage_i.asserts_i.error_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("a concurrent assertion on rsp_stage failed");
      abort_run();
    end
  end

endmodule

// ==== tb.f ====
logic/cache_pkg.sv
logic/lookup_if.sv
logic/tag_stage.sv
logic/data_array.sv
logic/rsp_stage.sv
logic/d_cache.sv
tb/d_cache_asserts.sv
tb/d_cache_tb.sv
